/* files.f */
leaf_pkg.sv
stream_fifo.sv
leaf_ingress.sv
leaf_egress.sv
leaf_interface.sv
user_kernel.sv
leaf_i2o3.sv
tb_leaf_i2o3.sv

/* tb_leaf_i2o3.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_leaf_i2o3;
    import leaf_pkg::*;

    localparam int                   CLK_PERIOD  = 10;
    localparam logic [LEAF_BITS-1:0] LEAF_ID     = 5'd9;
    localparam int                   N_HELD      = 8;   // Pairs sent before ap_start.
    localparam int                   N_PAIRS     = 40;
    localparam int                   N_RES       = 6;   // Pairs sent around the resend window.
    localparam int                   MAX_GAP     = 5;
    localparam int                   MAX_TOTAL   = N_HELD + N_PAIRS + N_RES;
    localparam int                   STIM_CYCLES = 10 + 8 + N_HELD * 4
                                                 + N_PAIRS * (2 + 2 * MAX_GAP) + N_RES * 4 + 100;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      resend;
    logic      ap_start;
    leaf_pkt_t din;
    leaf_pkt_t dout;

    logic [31:0] lfsr_state = 32'h5744_48ae;
    logic [31:0] pend1 [$];
    logic [31:0] pend2 [$];
    logic [31:0] pair_a [MAX_TOTAL];
    logic [31:0] pair_b [MAX_TOTAL];
    int          n_pairs = 0;
    int          got [1:3];
    route_t      route_exp [1:3];
    logic        start_seen;
    int          s;

    always #(CLK_PERIOD / 2) clk = ~clk;

    leaf_i2o3 #(
        .LEAF_ID    (LEAF_ID),
        .FIFO_DEPTH (16)
    ) UUT (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    // Galois form, x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] st);
        return st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] expected_word(input int st, input logic [31:0] a,
                                                  input logic [31:0] b);
        case (st)
            1:       return a + b;
            2:       return a - b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            din = '0;
        end
    endtask

    task automatic send_pkt(input logic [LEAF_BITS-1:0] leaf, input logic [PORT_BITS-1:0] port,
                            input logic [ADDR_BITS-1:0] addr, input logic [31:0] payload,
                            input logic v);
        @(negedge clk);
        din.vld       = v;
        din.dest_leaf = leaf;
        din.dest_port = port;
        din.addr      = addr;
        din.payload   = payload;
    endtask

    task automatic send_word(input int which, input logic [31:0] w);
        logic [31:0] r;
        rand_bits(ADDR_BITS, r);
        send_pkt(LEAF_ID, (which == 1) ? port_in1 : port_in2, r[ADDR_BITS-1:0], w, 1'b1);
        if (which == 1) pend1.push_back(w);
        else pend2.push_back(w);
        if (pend1.size() > 0 && pend2.size() > 0) begin  // Kernel pairs queue heads in order.
            pair_a[n_pairs] = pend1.pop_front();
            pair_b[n_pairs] = pend2.pop_front();
            n_pairs++;
        end
    endtask

    // Idle cycle, foreign leaf, bad port on this leaf, or a packet with vld low.
    task automatic send_junk();
        logic [31:0] kind;
        logic [31:0] r;
        logic [31:0] p;
        rand_bits(2, kind);
        rand_bits(32, p);
        rand_bits(ADDR_BITS, r);
        case (kind[1:0])
            2'd0: idle_cycles(1);
            2'd1: begin
                rand_bits(LEAF_BITS + PORT_BITS, r);
                if (r[8:4] == '0) r[8:4] = 5'd1;
                send_pkt(LEAF_ID ^ r[8:4], r[3:0], r[6:0], p, 1'b1);
            end
            2'd2: begin
                rand_bits(PORT_BITS, r);
                send_pkt(LEAF_ID, PORT_BITS'(r % 13 + 3), 7'd1, p, 1'b1);
            end
            default: send_pkt(LEAF_ID, port_in1, r[6:0], p, 1'b0);
        endcase
    endtask

    task automatic send_pair(input int gap_min, input int gap_max);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int          gap;
        rand_bits(32, a);
        rand_bits(32, b);
        rand_bits(4, r);
        gap = gap_min + r[3:1] % (gap_max - gap_min + 1);
        send_word(r[0] ? 1 : 2, r[0] ? a : b);
        repeat (gap) send_junk();
        send_word(r[0] ? 2 : 1, r[0] ? b : a);
        repeat (gap) send_junk();
    endtask

    task automatic wait_drain();
        while (!(got[1] == n_pairs && got[2] == n_pairs && got[3] == n_pairs)) idle_cycles(1);
    endtask

    // Output checks, sampled before the egress register updates.
    always @(posedge clk) begin
        if (!arst_n) assert (!dout.vld) else report_error("output vld high during reset");
        if (!start_seen) assert (!dout.vld) else report_error("output packet before ap_start");
        if (resend) assert (dout == '0) else report_error("output not blanked during resend");
        if (dout.vld) begin
            s = int'(dout.addr);
            assert (s >= 1 && s <= 3)
                else report_error($sformatf("output addr %0d is no stream number", s));
            assert ({dout.dest_leaf, dout.dest_port} == route_exp[s])
                else report_error($sformatf("stream %0d route %h, expected %h", s,
                                            {dout.dest_leaf, dout.dest_port}, route_exp[s]));
            assert (got[s] < n_pairs)
                else report_error($sformatf("extra packet on stream %0d", s));
            assert (dout.payload == expected_word(s, pair_a[got[s]], pair_b[got[s]]))
                else report_error($sformatf("stream %0d payload %h, expected %h", s,
                                  dout.payload, expected_word(s, pair_a[got[s]], pair_b[got[s]])));
            got[s]++;
        end
    end

    initial begin
        #(20 * STIM_CYCLES * CLK_PERIOD);
        $display("Timeout: the expected packets did not all arrive in time");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        arst_n     = 1'b1;
        resend     = 1'b0;
        ap_start   = 1'b0;
        din        = '0;
        start_seen = 1'b0;
        for (int k = 1; k <= 3; k++) got[k] = 0;
        #1;
        arst_n = 1'b0;
        idle_cycles(10);
        arst_n = 1'b1;
        idle_cycles(2);

        for (int k = 1; k <= 3; k++) begin  // Route table setup on port 0.
            rand_bits(32, r);
            route_exp[k] = route_t'(r[8:0]);
            send_pkt(LEAF_ID, port_config, ADDR_BITS'(k), r, 1'b1);
            send_junk();
        end

        repeat (N_HELD) send_pair(0, 1);
        idle_cycles(12);
        ap_start   = 1'b1;
        start_seen = 1'b1;
        idle_cycles(1);
        ap_start = 1'b0;
        wait_drain();

        repeat (N_PAIRS) send_pair(2, MAX_GAP);
        wait_drain();

        repeat (2) send_pair(1, 1);
        while (!dout.vld) idle_cycles(1);
        resend = 1'b1;  // A packet sits in the egress register and is blanked.
        repeat (N_RES - 2) send_pair(1, 1);
        idle_cycles(10);
        resend = 1'b0;
        wait_drain();
        idle_cycles(20);

        if (pend1.size() == 0 && pend2.size() == 0 && n_pairs == MAX_TOTAL) begin
            $display("sim passed");
            $finish;
        end else begin
            report_error("pairs left unmatched at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* leaf_i2o3.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_i2o3 #(
    parameter logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ID    = 5'd1,
    parameter int                             FIFO_DEPTH = 16
) (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire leaf_pkg::leaf_pkt_t din_leaf_bft2interface,
    output leaf_pkg::leaf_pkt_t      dout_leaf_interface2bft,
    input  wire logic                resend,
    input  wire logic                ap_start
);
    import leaf_pkg::*;

    logic                         reset_ap_start_user;
    logic [1:0][PAYLOAD_BITS-1:0] dout_leaf_interface2user;
    logic [1:0]                   vld_interface2user;
    logic [1:0]                   ack_user2interface;
    logic [2:0][PAYLOAD_BITS-1:0] din_leaf_user2interface;
    logic [2:0]                   vld_user2interface;
    logic [2:0]                   ack_interface2user;
    leaf_pkt_t                    dout_leaf_interface2bft_tmp;

    assign dout_leaf_interface2bft = resend ? '0 : dout_leaf_interface2bft_tmp;  // Blanked.

    leaf_interface #(
        .LEAF_ID    (LEAF_ID),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_leaf_interface (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft_tmp),
        .resend                   (resend),
        .ap_start                 (ap_start),
        .reset_ap_start_user      (reset_ap_start_user),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

    user_kernel u_user_kernel (
        .clk      (clk),
        .reset    (reset_ap_start_user),
        .arst_n   (arst_n),
        .in1_data (dout_leaf_interface2user[0]),
        .in1_vld  (vld_interface2user[0]),
        .in1_ack  (ack_user2interface[0]),
        .in2_data (dout_leaf_interface2user[1]),
        .in2_vld  (vld_interface2user[1]),
        .in2_ack  (ack_user2interface[1]),
        .out_data (din_leaf_user2interface),
        .out_vld  (vld_user2interface),
        .out_ack  (ack_interface2user)
    );

endmodule

`default_nettype wire

/* user_kernel.sv */
`timescale 1ns/1ps
`default_nettype none

module user_kernel (
    input  wire logic                                   clk,
    input  wire logic                                   reset,
    input  wire logic                                   arst_n,
    input  wire logic [leaf_pkg::PAYLOAD_BITS-1:0]      in1_data,
    input  wire logic                                   in1_vld,
    output logic                                        in1_ack,
    input  wire logic [leaf_pkg::PAYLOAD_BITS-1:0]      in2_data,
    input  wire logic                                   in2_vld,
    output logic                                        in2_ack,
    output logic [2:0][leaf_pkg::PAYLOAD_BITS-1:0]      out_data,
    output logic [2:0]                                  out_vld,
    input  wire logic [2:0]                             out_ack
);
    import leaf_pkg::*;

    logic running;
    logic room;
    logic take;

    // Every result slot is empty or drains this cycle.
    assign room    = &(~out_vld | out_ack);
    assign take    = running && in1_vld && in2_vld && room;
    assign in1_ack = take;
    assign in2_ack = take;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            out_vld <= '0;
        end else if (reset) begin
            running <= 1'b0;
            out_vld <= '0;
        end else begin
            running <= 1'b1;
            for (int k = 0; k < 3; k++) begin
                if (take) begin
                    out_vld[k] <= 1'b1;
                end else if (out_ack[k]) begin
                    out_vld[k] <= 1'b0;
                end
            end
        end
    end

    // Stream 1 sum, stream 2 difference, stream 3 xor.
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= {in1_data ^ in2_data, in1_data - in2_data, in1_data + in2_data};
        end
    end

endmodule

`default_nettype wire

/* leaf_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_interface #(
    parameter logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ID    = '0,
    parameter int                             FIFO_DEPTH = 16
) (
    input  wire logic                                   clk,
    input  wire logic                                   arst_n,
    input  wire leaf_pkg::leaf_pkt_t                    din_leaf_bft2interface,
    output leaf_pkg::leaf_pkt_t                         dout_leaf_interface2bft,
    input  wire logic                                   resend,
    input  wire logic                                   ap_start,
    output logic                                        reset_ap_start_user,
    output logic [1:0][leaf_pkg::PAYLOAD_BITS-1:0]      dout_leaf_interface2user,
    output logic [1:0]                                  vld_interface2user,
    input  wire logic [1:0]                             ack_user2interface,
    input  wire logic [2:0][leaf_pkg::PAYLOAD_BITS-1:0] din_leaf_user2interface,
    input  wire logic [2:0]                             vld_user2interface,
    output logic [2:0]                                  ack_interface2user
);
    import leaf_pkg::*;

    logic [1:0]                   push;
    logic [1:0][PAYLOAD_BITS-1:0] push_data;
    logic [1:0]                   full;
    logic                         route_we;
    logic [1:0]                   route_sel;
    route_t                       route_data;

    // Kernel stays in reset until ap_start is first seen.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reset_ap_start_user <= 1'b1;
        end else if (ap_start) begin
            reset_ap_start_user <= 1'b0;
        end
    end

    leaf_ingress #(
        .LEAF_ID(LEAF_ID)
    ) u_ingress (
        .clk        (clk),
        .arst_n     (arst_n),
        .pkt        (din_leaf_bft2interface),
        .push       (push),
        .push_data  (push_data),
        .full       (full),
        .route_we   (route_we),
        .route_sel  (route_sel),
        .route_data (route_data)
    );

    for (genvar i = 0; i < 2; i++) begin : g_in_q
        stream_fifo #(
            .DEPTH(FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .arst_n    (arst_n),
            .push      (push[i]),
            .push_data (push_data[i]),
            .full      (full[i]),
            .data      (dout_leaf_interface2user[i]),
            .vld       (vld_interface2user[i]),
            .ack       (ack_user2interface[i])
        );
    end

    leaf_egress u_egress (
        .clk        (clk),
        .arst_n     (arst_n),
        .resend     (resend),
        .route_we   (route_we),
        .route_sel  (route_sel),
        .route_data (route_data),
        .data       (din_leaf_user2interface),
        .vld        (vld_user2interface),
        .ack        (ack_interface2user),
        .pkt        (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

/* leaf_egress.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_egress (
    input  wire logic                                   clk,
    input  wire logic                                   arst_n,
    input  wire logic                                   resend,
    input  wire logic                                   route_we,
    input  wire logic [1:0]                             route_sel,
    input  wire leaf_pkg::route_t                       route_data,
    input  wire logic [2:0][leaf_pkg::PAYLOAD_BITS-1:0] data,
    input  wire logic [2:0]                             vld,
    output logic [2:0]                                  ack,
    output leaf_pkg::leaf_pkt_t                         pkt
);
    import leaf_pkg::*;

    route_t     route_tab [1:3];
    logic [1:0] last;       // Last stream served, 0 to 2.
    logic [1:0] pick;
    logic       pick_ok;
    leaf_pkt_t  next_pkt;

    // Stream index step+1 places after base, modulo 3.
    function automatic logic [1:0] rr_slot(input logic [1:0] base, input logic [1:0] step);
        logic [2:0] sum;
        sum = 3'(base) + 3'(step) + 3'd1;
        return (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];
    endfunction

    // Lowest step wins, so the search starts after the last stream served.
    always_comb begin
        pick    = last;
        pick_ok = 1'b0;
        for (int k = 2; k >= 0; k--) begin
            if (vld[rr_slot(last, 2'(k))]) begin
                pick    = rr_slot(last, 2'(k));
                pick_ok = 1'b1;
            end
        end
    end

    always_comb begin
        ack = 3'b000;
        if (pick_ok && !resend) begin
            ack[pick] = 1'b1;
        end
    end

    always_comb begin
        next_pkt           = '0;
        next_pkt.vld       = 1'b1;
        next_pkt.dest_leaf = route_tab[pick + 2'd1].dest_leaf;
        next_pkt.dest_port = route_tab[pick + 2'd1].dest_port;
        next_pkt.addr      = ADDR_BITS'(pick) + 1'b1;  // Streams are numbered from 1.
        next_pkt.payload   = data[pick];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            route_tab <= '{default: '0};
            last      <= 2'd2;
            pkt       <= '0;
        end else begin
            if (route_we && route_sel != 2'd0) begin
                route_tab[route_sel] <= route_data;
            end
            // Packet is held while resend is high.
            if (!resend) begin
                if (pick_ok) begin
                    pkt  <= next_pkt;
                    last <= pick;
                end else begin
                    pkt <= '0;  // Idle cycle.
                end
            end
        end
    end

endmodule

`default_nettype wire

/* leaf_ingress.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_ingress #(
    parameter logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ID = '0
) (
    input  wire logic                                   clk,
    input  wire logic                                   arst_n,
    input  wire leaf_pkg::leaf_pkt_t                    pkt,
    output logic [1:0]                                  push,
    output logic [1:0][leaf_pkg::PAYLOAD_BITS-1:0]      push_data,
    input  wire logic [1:0]                             full,
    output logic                                        route_we,
    output logic [1:0]                                  route_sel,
    output leaf_pkg::route_t                            route_data
);
    import leaf_pkg::*;

    logic hit;
    logic addr_ok;
    logic cfg;

    assign hit     = pkt.vld && (pkt.dest_leaf == LEAF_ID);
    assign addr_ok = (pkt.addr[ADDR_BITS-1:2] == '0) && (pkt.addr[1:0] != 2'd0);

    // Push is decoded straight from the packet, so the queue write lands on this edge.
    always_comb begin
        push = 2'b00;
        cfg  = 1'b0;
        if (hit) begin
            case (pkt.dest_port)
                port_in1:    push[0] = !full[0];  // Dropped when full.
                port_in2:    push[1] = !full[1];
                port_config: cfg     = addr_ok;
                default:     ;
            endcase
        end
    end

    assign push_data = {2{pkt.payload}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            route_we <= 1'b0;
        end else begin
            route_we <= cfg;
        end
    end

    // Entry number 1 to 3 and new route.
    always_ff @(posedge clk) begin
        if (cfg) begin
            route_sel  <= pkt.addr[1:0];
            route_data <= route_t'(pkt.payload[$bits(route_t)-1:0]);
        end
    end

endmodule

`default_nettype wire

/* stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int DEPTH = 16
) (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic                              push,
    input  wire logic [leaf_pkg::PAYLOAD_BITS-1:0] push_data,
    output logic                                   full,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]      data,
    output logic                                   vld,
    input  wire logic                              ack
);
    import leaf_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [PAYLOAD_BITS-1:0] mem [DEPTH];
    logic [AW:0]             wr_ptr;
    logic [AW:0]             rd_ptr;
    logic                    do_push;
    logic                    do_pop;

    // Extra pointer bit tells full from empty.
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign vld     = (wr_ptr != rd_ptr);
    assign data    = mem[rd_ptr[AW-1:0]];  // Head word.
    assign do_push = push && !full;
    assign do_pop  = vld && ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* leaf_pkg.sv */
`default_nettype none

package leaf_pkg;

    // Field widths of a fabric packet.
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    // One 49-bit packet on the fabric side, vld in the top bit.
    typedef struct packed {
        logic                    vld;
        logic [LEAF_BITS-1:0]    dest_leaf;
        logic [PORT_BITS-1:0]    dest_port;
        logic [ADDR_BITS-1:0]    addr;     // Stream number on egress.
        logic [PAYLOAD_BITS-1:0] payload;
    } leaf_pkt_t;

    // Destination of one output stream.
    typedef struct packed {
        logic [LEAF_BITS-1:0] dest_leaf;
        logic [PORT_BITS-1:0] dest_port;
    } route_t;

    // Meaning of the dest_port field at this leaf.
    typedef enum logic [PORT_BITS-1:0] {
        port_config = 4'd0,  // Route table writes.
        port_in1    = 4'd1,
        port_in2    = 4'd2
    } port_role_e;

endpackage

`default_nettype wire
